//--- Makefile
# Verilator build and run of the storage access testbench

sim:
	verilator --binary --timing -j 0 --top-module tb_gs_access -Mdir obj_dir -f project.f
	./obj_dir/Vtb_gs_access | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- hw/addr_capture.sv
module addr_capture (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                start,
   input  gs_pkg::gs_op_t      op,
   input  biq_pkg::biq_digit_t addr_th,
   input  biq_pkg::biq_digit_t addr_h,
   input  biq_pkg::biq_digit_t addr_t,
   input  biq_pkg::biq_digit_t addr_u,
   input  logic                retire,
   output logic                busy,
   gs_stage_if.src             out
);

   logic                accept;
   logic                code_ok;
   logic                valid_q;
   logic                err_q;
   gs_pkg::gs_op_t      op_q;
   biq_pkg::biq_digit_t th_q;
   biq_pkg::biq_digit_t h_q;
   biq_pkg::biq_digit_t t_q;
   biq_pkg::biq_digit_t u_q;

   // Only one access is in flight, so a start during busy is dropped
   assign accept = start && !busy;

   // Every one of the four address digits must carry a legal code
   assign code_ok = biq_pkg::biq_valid(addr_th) && biq_pkg::biq_valid(addr_h) &&
                    biq_pkg::biq_valid(addr_t)  && biq_pkg::biq_valid(addr_u);

   //////////////////////////////////////////////////
   // Request control and busy
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         valid_q <= 1'b0;
         err_q   <= 1'b0;
         op_q    <= gs_pkg::GS_READ;
      end else begin
         // Both flags are pulses that last one cycle after the accepting edge
         valid_q <= accept;
         err_q   <= accept && !code_ok;
         if (accept) begin
            busy <= 1'b1;
            op_q <= op;
         end else if (retire) begin
            // Retire comes from done or from a rejected address downstream
            busy <= 1'b0;
         end
      end
   end

   // Address digits are held as captured
   always_ff @(posedge clk) begin
      if (accept) begin
         th_q <= addr_th;
         h_q  <= addr_h;
         t_q  <= addr_t;
         u_q  <= addr_u;
      end
   end

   assign out.valid = valid_q;
   assign out.err   = err_q;
   assign out.op    = op_q;
   assign out.th    = th_q;
   assign out.h     = h_q;
   assign out.t     = t_q;
   assign out.u     = u_q;

   // The base address is only known after band decode
   assign out.base  = '0;

endmodule

//--- hw/band_decode.sv
module band_decode #(
   parameter int BANDS = 40,
   localparam int ADDR_W = $clog2(BANDS * gs_pkg::BAND_DIGITS)
) (
   input  logic    clk,
   input  logic    rst_n,
   gs_stage_if.dst in,
   gs_stage_if.src out
);

   logic [3:0]                  thou_v;
   logic [3:0]                  hund_v;
   logic [7:0]                  band;
   logic                        band_ok;
   logic [gs_pkg::OFFSET_W-1:0] offset;
   logic [ADDR_W-1:0]           base_next;
   logic                        valid_q;
   logic                        err_q;
   gs_pkg::gs_op_t              op_q;
   logic [ADDR_W-1:0]           base_q;

   // Word inside the band from the tens quinary and the units digit
   ram_word_offset u_word_offset (
      .addr_t (in.t),
      .addr_u (in.u),
      .offset (offset)
   );

   //////////////////////////////////////////////////
   // Band number and range check
   //////////////////////////////////////////////////

   assign thou_v = biq_pkg::biq_value(in.th);
   assign hund_v = biq_pkg::biq_value(in.h);

   // Each hundred spans two bands, the tens 5 bit picks the upper one
   assign band = 8'(thou_v) * 8'd20 + 8'(hund_v) * 8'd2 + 8'(in.t[biq_pkg::BI_LO]);
   assign band_ok = int'(band) < BANDS;

   assign base_next = ADDR_W'(band) * ADDR_W'(gs_pkg::BAND_DIGITS) + ADDR_W'(offset);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         valid_q <= in.valid;
         // A code error from capture wins over the band check
         err_q   <= in.valid && (in.err || !band_ok);
      end
   end

   always_ff @(posedge clk) begin
      if (in.valid) begin
         op_q   <= in.op;
         base_q <= base_next;
      end
   end

   assign out.valid = valid_q;
   assign out.err   = err_q;
   assign out.op    = op_q;
   assign out.base  = base_q;

   // Digits are consumed here
   assign out.th = '0;
   assign out.h  = '0;
   assign out.t  = '0;
   assign out.u  = '0;

endmodule

//--- hw/biq_pkg.sv
package biq_pkg;

   //////////////////////////////////////////////////
   // Biquinary digit layout
   //////////////////////////////////////////////////

   // Bit 0 is the bi 5 bit and bit 1 is the bi 0 bit
   // Bits 2..6 are the quinary one-hot, bit 2 weighs 4 and bit 6 weighs 0
   typedef logic [0:6] biq_digit_t;

   // Field positions inside a digit
   localparam int BI_LO  = 0;
   localparam int BI_HI  = 1;
   localparam int QUI_LO = 2;
   localparam int QUI_HI = 6;

   // A legal code has exactly one bi bit and exactly one quinary bit set
   function automatic logic biq_valid(biq_digit_t d);
      return $onehot(d[BI_LO:BI_HI]) && $onehot(d[QUI_LO:QUI_HI]);
   endfunction

   // Decimal value of a legal code, 0 to 9
   // The result for an illegal code has no meaning, callers check biq_valid first
   function automatic logic [3:0] biq_value(biq_digit_t d);
      logic [3:0] v;
      v = d[BI_LO] ? 4'd5 : 4'd0;
      for (int i = QUI_LO; i <= QUI_HI; i++) begin
         // Quinary weight falls from 4 at QUI_LO to 0 at QUI_HI
         if (d[i]) begin
            v = v + 4'(QUI_HI - i);
         end
      end
      return v;
   endfunction

endpackage

//--- hw/digit_sequencer.sv
module digit_sequencer #(
   parameter int BANDS = 40,
   localparam int ADDR_W = $clog2(BANDS * gs_pkg::BAND_DIGITS)
) (
   input  logic              clk,
   input  logic              rst_n,
   gs_stage_if.dst           in,
   output logic [ADDR_W-1:0] ram_addr,
   output logic              ram_we,
   output logic              ram_re,
   output logic              digit_strobe,
   output logic              rd_valid,
   output logic              done,
   output logic              addr_err
);

   gs_pkg::seq_state_t state_q;
   gs_pkg::gs_op_t     op_q;
   logic [3:0]         slot_q;
   logic [ADDR_W-1:0]  base_q;
   logic               active;
   logic               rd_valid_q;
   logic               rd_last_q;

   //////////////////////////////////////////////////
   // RAM strobes and status outputs
   //////////////////////////////////////////////////

   assign active   = state_q != gs_pkg::SEQ_IDLE;
   assign ram_we   = active && op_q == gs_pkg::GS_WRITE;
   assign ram_re   = active && op_q == gs_pkg::GS_READ;
   assign ram_addr = base_q + ADDR_W'(slot_q);

   // The write digit is taken in the same cycle as the RAM write
   assign digit_strobe = ram_we;

   // Read data arrives one cycle after its slot address
   assign rd_valid = rd_valid_q;

   // Writes finish with the last slot, reads with the last data digit
   assign done = (state_q == gs_pkg::SEQ_LAST && op_q == gs_pkg::GS_WRITE) || rd_last_q;

   // Rejected items stop here and never touch the RAM
   assign addr_err = in.valid && in.err;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q    <= gs_pkg::SEQ_IDLE;
         op_q       <= gs_pkg::GS_READ;
         slot_q     <= 4'd0;
         rd_valid_q <= 1'b0;
         rd_last_q  <= 1'b0;
      end else begin
         rd_valid_q <= ram_re;
         rd_last_q  <= ram_re && state_q == gs_pkg::SEQ_LAST;
         case (state_q)
            gs_pkg::SEQ_IDLE: begin
               if (in.valid && !in.err) begin
                  op_q    <= in.op;
                  slot_q  <= 4'd0;
                  state_q <= gs_pkg::SEQ_RUN;
               end
            end
            gs_pkg::SEQ_RUN: begin
               slot_q <= slot_q + 4'd1;
               // Slot 11 is the gap and is handled in SEQ_LAST
               if (slot_q == 4'(gs_pkg::WORD_DIGITS - 2)) begin
                  state_q <= gs_pkg::SEQ_LAST;
               end
            end
            gs_pkg::SEQ_LAST: begin
               state_q <= gs_pkg::SEQ_IDLE;
            end
            default: begin
               state_q <= gs_pkg::SEQ_IDLE;
            end
         endcase
      end
   end

   // Base of the word, loaded as the access starts
   always_ff @(posedge clk) begin
      if (state_q == gs_pkg::SEQ_IDLE && in.valid) begin
         base_q <= in.base;
      end
   end

endmodule

//--- hw/general_storage.sv
// Digit storage of the drum, one digit per location
// Band b starts at b times BAND_DIGITS and each word takes WORD_DIGITS slots
module general_storage #(
   parameter int BANDS = 40,
   localparam int DEPTH  = BANDS * gs_pkg::BAND_DIGITS,
   localparam int ADDR_W = $clog2(DEPTH)
) (
   input  logic                clk,
   input  logic [ADDR_W-1:0]   addr,
   input  logic                we,
   input  logic                re,
   input  biq_pkg::biq_digit_t wdata,
   output biq_pkg::biq_digit_t rdata
);

   //////////////////////////////////////////////////
   // Storage array
   //////////////////////////////////////////////////

   biq_pkg::biq_digit_t mem [DEPTH];

   // One port, the sequencer never raises we and re together
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
   end

   // Registered read, output holds between reads
   always_ff @(posedge clk) begin
      if (re) begin
         rdata <= mem[addr];
      end
   end

endmodule

//--- hw/gs_access_top.sv
module gs_access_top #(
   parameter int BANDS = 40
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                start,
   input  gs_pkg::gs_op_t      op,
   input  biq_pkg::biq_digit_t addr_th,
   input  biq_pkg::biq_digit_t addr_h,
   input  biq_pkg::biq_digit_t addr_t,
   input  biq_pkg::biq_digit_t addr_u,
   input  biq_pkg::biq_digit_t wr_digit,
   output logic                digit_strobe,
   output biq_pkg::biq_digit_t rd_digit,
   output logic                rd_valid,
   output logic                busy,
   output logic                addr_err,
   output logic                done
);

   localparam int ADDR_W = $clog2(BANDS * gs_pkg::BAND_DIGITS);

   logic              retire;
   logic [ADDR_W-1:0] ram_addr;
   logic              ram_we;
   logic              ram_re;

   gs_stage_if #(.BANDS(BANDS)) cap_if ();
   gs_stage_if #(.BANDS(BANDS)) dec_if ();

   // The access leaves flight on completion or on rejection
   assign retire = done || addr_err;

   //////////////////////////////////////////////////
   // Stage chain, capture then decode then sequence
   //////////////////////////////////////////////////

   addr_capture u_capture (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (start),
      .op      (op),
      .addr_th (addr_th),
      .addr_h  (addr_h),
      .addr_t  (addr_t),
      .addr_u  (addr_u),
      .retire  (retire),
      .busy    (busy),
      .out     (cap_if.src)
   );

   band_decode #(.BANDS(BANDS)) u_decode (
      .clk   (clk),
      .rst_n (rst_n),
      .in    (cap_if.dst),
      .out   (dec_if.src)
   );

   digit_sequencer #(.BANDS(BANDS)) u_sequencer (
      .clk          (clk),
      .rst_n        (rst_n),
      .in           (dec_if.dst),
      .ram_addr     (ram_addr),
      .ram_we       (ram_we),
      .ram_re       (ram_re),
      .digit_strobe (digit_strobe),
      .rd_valid     (rd_valid),
      .done         (done),
      .addr_err     (addr_err)
   );

   general_storage #(.BANDS(BANDS)) u_storage (
      .clk   (clk),
      .addr  (ram_addr),
      .we    (ram_we),
      .re    (ram_re),
      .wdata (wr_digit),
      .rdata (rd_digit)
   );

endmodule

//--- hw/gs_pkg.sv
package gs_pkg;

   //////////////////////////////////////////////////
   // Drum storage geometry
   //////////////////////////////////////////////////

   // Ten digits, the sign and the inter-word gap
   localparam int WORD_DIGITS = 12;

   // Words on one band of the drum
   localparam int BAND_WORDS = 50;

   // Digit slots on one band
   localparam int BAND_DIGITS = BAND_WORDS * WORD_DIGITS;

   // Offset of a word inside its band, enough for BAND_DIGITS
   localparam int OFFSET_W = 10;

   //////////////////////////////////////////////////
   // Access control types
   //////////////////////////////////////////////////

   // Direction of one storage access
   typedef enum logic [0:0] {
      GS_READ  = 1'b0,
      GS_WRITE = 1'b1
   } gs_op_t;

   // Digit sequencer states
   // SEQ_RUN covers slots 0 to 10 and SEQ_LAST holds the final slot
   typedef enum logic [1:0] {
      SEQ_IDLE = 2'd0,
      SEQ_RUN  = 2'd1,
      SEQ_LAST = 2'd2
   } seq_state_t;

endpackage

//--- hw/gs_stage_if.sv
// One pending storage access moving from one pipeline stage to the next
// Valid is a single cycle pulse and all other fields are only meaningful with it
interface gs_stage_if #(
   parameter int BANDS = 40,
   localparam int ADDR_W = $clog2(BANDS * gs_pkg::BAND_DIGITS)
);

   logic                valid;
   gs_pkg::gs_op_t      op;

   // Address digits, thousands down to units
   biq_pkg::biq_digit_t th;
   biq_pkg::biq_digit_t h;
   biq_pkg::biq_digit_t t;
   biq_pkg::biq_digit_t u;

   // First digit slot of the word in the storage RAM
   logic [ADDR_W-1:0]   base;

   // Set with valid when the address was rejected
   logic                err;

   // Producing stage
   modport src (output valid, op, th, h, t, u, base, err);

   // Consuming stage
   modport dst (input valid, op, th, h, t, u, base, err);

endinterface

//--- hw/ram_word_offset.sv
// Turns the dynamic part of a storage address into a digit offset in its band
// Tens quinary picks a group of ten words and the units digit picks the word
module ram_word_offset (
   input  biq_pkg::biq_digit_t           addr_t,
   input  biq_pkg::biq_digit_t           addr_u,
   output logic [gs_pkg::OFFSET_W-1:0]   offset
);

   // Quinary codes, value 0 sits in the last bit
   localparam logic [0:4] Q0 = 5'b00001;
   localparam logic [0:4] Q1 = 5'b00010;
   localparam logic [0:4] Q2 = 5'b00100;
   localparam logic [0:4] Q3 = 5'b01000;
   localparam logic [0:4] Q4 = 5'b10000;

   // Bi codes, the 0 bit is the second one
   localparam logic [0:1] B0 = 2'b01;
   localparam logic [0:1] B5 = 2'b10;

   always_comb begin
      // Each step of one word is WORD_DIGITS slots
      case ({addr_t[biq_pkg::QUI_LO:biq_pkg::QUI_HI], addr_u})
         // Tens 0 or 5
         {Q0, B0, Q0}: offset = 10'd0;
         {Q0, B0, Q1}: offset = 10'd12;
         {Q0, B0, Q2}: offset = 10'd24;
         {Q0, B0, Q3}: offset = 10'd36;
         {Q0, B0, Q4}: offset = 10'd48;
         {Q0, B5, Q0}: offset = 10'd60;
         {Q0, B5, Q1}: offset = 10'd72;
         {Q0, B5, Q2}: offset = 10'd84;
         {Q0, B5, Q3}: offset = 10'd96;
         {Q0, B5, Q4}: offset = 10'd108;
         // Tens 1 or 6
         {Q1, B0, Q0}: offset = 10'd120;
         {Q1, B0, Q1}: offset = 10'd132;
         {Q1, B0, Q2}: offset = 10'd144;
         {Q1, B0, Q3}: offset = 10'd156;
         {Q1, B0, Q4}: offset = 10'd168;
         {Q1, B5, Q0}: offset = 10'd180;
         {Q1, B5, Q1}: offset = 10'd192;
         {Q1, B5, Q2}: offset = 10'd204;
         {Q1, B5, Q3}: offset = 10'd216;
         {Q1, B5, Q4}: offset = 10'd228;
         // Tens 2 or 7
         {Q2, B0, Q0}: offset = 10'd240;
         {Q2, B0, Q1}: offset = 10'd252;
         {Q2, B0, Q2}: offset = 10'd264;
         {Q2, B0, Q3}: offset = 10'd276;
         {Q2, B0, Q4}: offset = 10'd288;
         {Q2, B5, Q0}: offset = 10'd300;
         {Q2, B5, Q1}: offset = 10'd312;
         {Q2, B5, Q2}: offset = 10'd324;
         {Q2, B5, Q3}: offset = 10'd336;
         {Q2, B5, Q4}: offset = 10'd348;
         // Tens 3 or 8
         {Q3, B0, Q0}: offset = 10'd360;
         {Q3, B0, Q1}: offset = 10'd372;
         {Q3, B0, Q2}: offset = 10'd384;
         {Q3, B0, Q3}: offset = 10'd396;
         {Q3, B0, Q4}: offset = 10'd408;
         {Q3, B5, Q0}: offset = 10'd420;
         {Q3, B5, Q1}: offset = 10'd432;
         {Q3, B5, Q2}: offset = 10'd444;
         {Q3, B5, Q3}: offset = 10'd456;
         {Q3, B5, Q4}: offset = 10'd468;
         // Tens 4 or 9
         {Q4, B0, Q0}: offset = 10'd480;
         {Q4, B0, Q1}: offset = 10'd492;
         {Q4, B0, Q2}: offset = 10'd504;
         {Q4, B0, Q3}: offset = 10'd516;
         {Q4, B0, Q4}: offset = 10'd528;
         {Q4, B5, Q0}: offset = 10'd540;
         {Q4, B5, Q1}: offset = 10'd552;
         {Q4, B5, Q2}: offset = 10'd564;
         {Q4, B5, Q3}: offset = 10'd576;
         {Q4, B5, Q4}: offset = 10'd588;
         // Illegal codes are caught in address capture
         default:      offset = 10'd0;
      endcase
   end

endmodule

//--- project.f
hw/biq_pkg.sv
hw/gs_pkg.sv
hw/gs_stage_if.sv
hw/ram_word_offset.sv
hw/addr_capture.sv
hw/band_decode.sv
hw/digit_sequencer.sv
hw/general_storage.sv
hw/gs_access_top.sv
test/tb_gs_access.sv

//--- test/gs_cases.txt
# Columns: op (W or R), decimal address, corruption selector
# Selector 0 none, 1..4 extra quinary bit in th/h/t/u, 5..8 no bi bit, 9 second start
W 0000 0
W 0049 0
W 0050 0
W 0061 0
W 0172 0
W 0283 0
W 0394 0
W 1999 0
W 1949 0
W 1005 0
W 0716 0
W 1527 0
W 0838 0
R 0000 0
R 0049 0
R 0050 0
R 0061 0
R 0172 0
R 0283 0
R 0394 0
R 1999 0
R 1949 0
R 1005 0
R 0716 0
R 1527 0
R 0838 0
W 0049 3
W 0050 8
R 0049 0
R 0050 0
W 2000 0
R 9999 0
W 1948 9
R 1948 0
R 1949 0
R 1005 5
W 0838 1
R 0838 0
W 3050 0
R 0050 0

//--- test/tb_gs_access.sv
module tb_gs_access;

   localparam int BANDS  = 40;
   localparam int PERIOD = 10;

   logic                clk = 1'b0;
   logic                rst_n;
   logic                start;
   gs_pkg::gs_op_t      op;
   biq_pkg::biq_digit_t addr_th;
   biq_pkg::biq_digit_t addr_h;
   biq_pkg::biq_digit_t addr_t;
   biq_pkg::biq_digit_t addr_u;
   biq_pkg::biq_digit_t wr_digit;
   logic                digit_strobe;
   biq_pkg::biq_digit_t rd_digit;
   logic                rd_valid;
   logic                busy;
   logic                addr_err;
   logic                done;

   // Cases as read from the data file
   bit          case_write [$];
   int          case_addr [$];
   int          case_sel [$];
   bit          loaded = 1'b0;

   // Expected word per decimal address with slot k in bits k*7 upward
   logic [83:0] model [int];
   logic [15:0] lfsr = 16'd98;
   int          errors = 0;
   int          failed_cases = 0;

   gs_access_top #(.BANDS(BANDS)) dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .op           (op),
      .addr_th      (addr_th),
      .addr_h       (addr_h),
      .addr_t       (addr_t),
      .addr_u       (addr_u),
      .wr_digit     (wr_digit),
      .digit_strobe (digit_strobe),
      .rd_digit     (rd_digit),
      .rd_valid     (rd_valid),
      .busy         (busy),
      .addr_err     (addr_err),
      .done         (done)
   );

   always #(PERIOD / 2) clk = ~clk;

   //////////////////////////////////////////////////
   // Reference model helpers
   //////////////////////////////////////////////////

   // The bi pair says 5 or 0 and the quinary one-hot gives the rest with weight 0 at QUI_HI
   function automatic biq_pkg::biq_digit_t encode_digit(int v);
      biq_pkg::biq_digit_t d;
      d = '0;
      d[biq_pkg::BI_LO] = (v >= 5);
      d[biq_pkg::BI_HI] = (v < 5);
      d[biq_pkg::QUI_HI - (v % 5)] = 1'b1;
      return d;
   endfunction

   // Selectors 1..4 add a second quinary bit and 5..8 remove the bi pair
   function automatic biq_pkg::biq_digit_t corrupt_digit(biq_pkg::biq_digit_t d, int sel);
      biq_pkg::biq_digit_t c;
      c = d;
      if (sel <= 4) begin
         if (d[biq_pkg::QUI_LO]) begin
            c[biq_pkg::QUI_HI] = 1'b1;
         end else begin
            c[biq_pkg::QUI_LO] = 1'b1;
         end
      end else begin
         c[biq_pkg::BI_LO] = 1'b0;
         c[biq_pkg::BI_HI] = 1'b0;
      end
      return c;
   endfunction

   // Band is thousands times 20 plus hundreds times 2 plus one for tens of 5 or more
   function automatic bit expect_reject(int addr, int sel);
      int band;
      band = (addr / 1000) * 20 + ((addr / 100) % 10) * 2 + (((addr / 10) % 10) >= 5 ? 1 : 0);
      return (sel >= 1 && sel <= 8) || band >= BANDS;
   endfunction

   // Galois LFSR with taps 16, 14, 13 and 11
   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // Data digits are raw, so all seven bits come straight from the LFSR
   task automatic random_digit(output biq_pkg::biq_digit_t d);
      for (int i = 0; i < 7; i++) begin
         d[i] = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus and checking
   //////////////////////////////////////////////////

   // Called just after a rising edge so the DUT sees start at the following edge
   task automatic drive_request(bit wr, int addr, int sel);
      biq_pkg::biq_digit_t dg [4];
      dg[0] = encode_digit(addr / 1000);
      dg[1] = encode_digit((addr / 100) % 10);
      dg[2] = encode_digit((addr / 10) % 10);
      dg[3] = encode_digit(addr % 10);
      if (sel >= 1 && sel <= 8) begin
         dg[(sel - 1) % 4] = corrupt_digit(dg[(sel - 1) % 4], sel);
      end
      op      <= wr ? gs_pkg::GS_WRITE : gs_pkg::GS_READ;
      addr_th <= dg[0];
      addr_h  <= dg[1];
      addr_t  <= dg[2];
      addr_u  <= dg[3];
      start   <= 1'b1;
   endtask

   task automatic check_count(int n, string what, int got, int want);
      if (got != want) begin
         $display("Fail case %0d: %s pulses expected %h got %h", n, what, want, got);
         errors++;
      end
   endtask

   task automatic check_idle(string name, logic v);
      if (v !== 1'b0) begin
         $display("Fail after reset: %s expected %h got %h", name, 1'b0, v);
         errors++;
      end
   endtask

   task automatic run_case(int n, bit wr, int addr, int sel);
      logic [83:0]         wdata;
      logic [83:0]         expw;
      biq_pkg::biq_digit_t d;
      bit                  reject;
      bit                  known;
      int                  cyc;
      int                  finish_cyc;
      int                  want_cyc;
      int                  tail;
      int                  strobes;
      int                  reads;
      int                  dones;
      int                  errs;
      int                  errors_before;
      reject = expect_reject(addr, sel);
      known = model.exists(addr);
      expw = known ? model[addr] : '0;
      errors_before = errors;
      for (int i = 0; i < 12; i++) begin
         random_digit(d);
         wdata[i*7 +: 7] = d;
      end
      @(posedge clk);
      drive_request(wr, addr, sel);
      wr_digit <= wdata[6:0];
      // The DUT takes the request at this edge and that edge is cycle 0
      @(posedge clk);
      start <= 1'b0;
      cyc = 0;
      finish_cyc = -1;
      tail = 1;
      strobes = 0;
      reads = 0;
      dones = 0;
      errs = 0;
      // Each pass sees the values of cycle cyc just before its closing edge
      while (finish_cyc < 0 || cyc < finish_cyc + tail) begin
         @(posedge clk);
         cyc++;
         // A second request in the middle of the access must be dropped
         if (sel == 9 && cyc == 4) begin
            drive_request(1'b1, (addr + 1) % 10000, 0);
         end else if (sel == 9 && cyc == 5) begin
            start <= 1'b0;
         end
         if (finish_cyc < 0 && busy !== 1'b1) begin
            $display("Fail case %0d: busy in cycle %0d expected %h got %h", n, cyc, 1'b1, busy);
            errors++;
         end
         if (finish_cyc >= 0 && cyc == finish_cyc + 1 && busy !== 1'b0) begin
            $display("Fail case %0d: busy in cycle %0d expected %h got %h", n, cyc, 1'b0, busy);
            errors++;
         end
         if (digit_strobe === 1'b1) begin
            // The RAM took the current digit at this edge, so offer the next one
            strobes++;
            if (strobes < 12) begin
               wr_digit <= wdata[strobes*7 +: 7];
            end
         end
         if (rd_valid === 1'b1) begin
            if (known && reads < 12 && rd_digit !== expw[reads*7 +: 7]) begin
               $display("Fail case %0d: rd_digit slot %0d expected %h got %h",
                        n, reads, expw[reads*7 +: 7], rd_digit);
               errors++;
            end
            reads++;
         end
         if (done === 1'b1) begin
            dones++;
            if (finish_cyc < 0) begin
               finish_cyc = cyc;
            end
         end
         if (addr_err === 1'b1) begin
            errs++;
            if (finish_cyc < 0) begin
               // Watch long enough that a stray access would show up
               finish_cyc = cyc;
               tail = 14;
            end
         end
      end
      // A rejected address ends in cycle 2, a write with its last slot and a read one later
      want_cyc = reject ? 2 : (wr ? 14 : 15);
      if (finish_cyc != want_cyc) begin
         $display("case %0d: the access ended in cycle %0d instead of cycle %0d",
                  n, finish_cyc, want_cyc);
         errors++;
      end
      check_count(n, "addr_err", errs, reject ? 1 : 0);
      check_count(n, "done", dones, reject ? 0 : 1);
      check_count(n, "digit_strobe", strobes, (!reject && wr) ? 12 : 0);
      check_count(n, "rd_valid", reads, (!reject && !wr) ? 12 : 0);
      if (!reject && wr) begin
         model[addr] = wdata;
      end
      if (errors == errors_before) begin
         $display("case %0d: %s %04d sel %0d passed", n, wr ? "W" : "R", addr, sel);
      end else begin
         $display("case %0d: %s %04d sel %0d failed", n, wr ? "W" : "R", addr, sel);
         failed_cases++;
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      int    fd;
      int    got;
      int    a;
      int    s;
      string line;
      string op_s;
      rst_n    = 1'b0;
      start    = 1'b0;
      op       = gs_pkg::GS_READ;
      addr_th  = '0;
      addr_h   = '0;
      addr_t   = '0;
      addr_u   = '0;
      wr_digit = '0;
      fd = $fopen("test/gs_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open the cases file test/gs_cases.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            got = $fgets(line, fd);
            // Lines starting with a hash are comments
            if (got > 0 && line[0] != "#") begin
               if ($sscanf(line, "%s %d %d", op_s, a, s) == 3) begin
                  case_write.push_back(op_s == "W");
                  case_addr.push_back(a);
                  case_sel.push_back(s);
               end
            end
         end
         $fclose(fd);
      end
      loaded = 1'b1;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      check_idle("busy", busy);
      check_idle("done", done);
      check_idle("addr_err", addr_err);
      check_idle("digit_strobe", digit_strobe);
      check_idle("rd_valid", rd_valid);
      for (int i = 0; i < case_addr.size(); i++) begin
         run_case(i, case_write[i], case_addr[i], case_sel[i]);
      end
      $display("%0d cases run, %0d cases failed, %0d errors",
               case_addr.size(), failed_cases, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // Watchdog that allows about twenty cycles per access plus a reset margin
   initial begin
      int limit;
      wait (loaded);
      limit = case_addr.size() * 20 + 50;
      #(limit * PERIOD);
      $display("Timeout: the run did not finish within %0d clock periods", limit);
      $display("Errors found");
      $finish;
   end

endmodule
